/* ising_consts.svh */
/*
 * Size constants for the spin-update stage:
 * spin count, block geometry, weight and energy widths,
 * and the APB address width.
 */
`ifndef ISING_CONSTS_SVH
`define ISING_CONSTS_SVH

`define NUM_SPIN      16
`define PARALLELISM   4
`define NUM_BLOCK     4

// signed widths
`define WEIGHT_BITS   4
`define ENERGY_BITS   16

`define APB_ADDR_BITS 8

`endif

/* ising_pkg.sv */
/*
 * Datapath types of the annealer update stage:
 * spin vector, energy, field weight, block index,
 * block flip mask and one block's weight word.
 */
`default_nettype none

`include "ising_consts.svh"

package ising_pkg;

    // 1 is spin +1, 0 is spin -1
    typedef logic [`NUM_SPIN-1:0] spin_vec_t;

    typedef logic signed [`ENERGY_BITS-1:0] energy_t;
    typedef logic signed [`WEIGHT_BITS-1:0] weight_t;

    typedef logic [$clog2(`NUM_BLOCK)-1:0] block_addr_t;
    typedef logic [`PARALLELISM-1:0] block_mask_t;

    // weight of spin i of the block sits in element i
    typedef weight_t [`PARALLELISM-1:0] field_word_t;

endpackage

`default_nettype wire

/* apb_regs_pkg.sv */
/*
 * APB register map of the update stage
 * and the layout of the control register.
 */
`default_nettype none

`include "ising_consts.svh"

package apb_regs_pkg;

    localparam logic [`APB_ADDR_BITS-1:0] REG_CTRL        = 8'h00;
    localparam logic [`APB_ADDR_BITS-1:0] REG_BOUND       = 8'h04;
    localparam logic [`APB_ADDR_BITS-1:0] REG_BASE_SPIN   = 8'h08;
    localparam logic [`APB_ADDR_BITS-1:0] REG_BASE_ENERGY = 8'h0C;
    localparam logic [`APB_ADDR_BITS-1:0] REG_STATUS      = 8'h10;
    // four words, one per block
    localparam logic [`APB_ADDR_BITS-1:0] REG_FIELD       = 8'h40;

    typedef struct packed {
        logic flush;
        logic enable;
    } ctrl_reg_t;

endpackage

`default_nettype wire

/* ising_ifs.sv */
/*
 * Internal valid/ready links:
 *   block_req_if  block read requests, filter to execute
 *   delta_if      energy change per proposal, execute to result
 */
`timescale 1ns/1ps
`default_nettype none

interface block_req_if import ising_pkg::*; ();
    logic        valid;
    logic        ready;
    logic        last;
    block_addr_t addr;
    block_mask_t mask;
    // new spin values of the addressed block
    block_mask_t spin;

    modport src (output valid, last, addr, mask, spin, input ready);
    modport dst (input valid, last, addr, mask, spin, output ready);
endinterface

interface delta_if import ising_pkg::*; ();
    logic      valid;
    logic      ready;
    energy_t   delta;
    // flipped positions of the proposal within the bound
    spin_vec_t flips;

    modport src (output valid, delta, flips, input ready);
    modport dst (input valid, delta, flips, output ready);
endinterface

`default_nettype wire

/* apb_ctrl.sv */
/*
 * APB slave of the update stage: control, scan bound,
 * baseline staging registers, accepted counter and
 * the field weight table with its read port.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ising_consts.svh"

module apb_ctrl import ising_pkg::*, apb_regs_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire logic                      psel_i,
    input  wire logic                      penable_i,
    input  wire logic                      pwrite_i,
    input  wire logic [`APB_ADDR_BITS-1:0] paddr_i,
    input  wire logic [31:0]               pwdata_i,
    output logic      [31:0]               prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  wire logic                      busy_i,
    input  wire logic                      accept_pulse_i,
    output logic                           enable_o,
    output logic                           flush_o,
    output block_addr_t                    bound_o,
    input  wire block_addr_t               field_addr_i,
    output field_word_t                    field_word_o,
    output logic                           base_load_o,
    output spin_vec_t                      base_spin_o,
    output energy_t                        base_energy_o
);
    logic        access;
    logic        wr;
    logic        hit;
    logic        field_sel;
    block_addr_t field_idx;
    ctrl_reg_t   ctrl_q;
    block_addr_t bound_q;
    spin_vec_t   base_spin_q;
    energy_t     base_energy_q;
    logic        base_load_q;
    logic [7:0]  accept_cnt_q;
    field_word_t field_q [`NUM_BLOCK];

    assign access    = psel_i & penable_i;
    assign wr        = access & pwrite_i;
    assign field_sel = (paddr_i[7:4] == REG_FIELD[7:4]) && (paddr_i[1:0] == 2'b00);
    assign field_idx = block_addr_t'(paddr_i[3:2]);

    always_comb begin
        hit      = 1'b1;
        prdata_o = '0;
        case (paddr_i)
            REG_CTRL:        prdata_o = 32'(ctrl_q);
            REG_BOUND:       prdata_o = 32'(bound_q);
            REG_BASE_SPIN:   prdata_o = 32'(base_spin_q);
            REG_BASE_ENERGY: prdata_o = 32'(unsigned'(base_energy_q));
            REG_STATUS:      prdata_o = {16'b0, accept_cnt_q, 7'b0, busy_i};
            default: begin
                hit = field_sel;
                if (field_sel) begin
                    prdata_o = 32'(field_q[field_idx]);
                end
            end
        endcase
    end

    // zero wait states
    assign pready_o  = access;
    assign pslverr_o = access & ~hit;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q        <= '0;
            bound_q       <= '1;
            base_spin_q   <= '0;
            base_energy_q <= '0;
            base_load_q   <= 1'b0;
            accept_cnt_q  <= '0;
            for (int b = 0; b < `NUM_BLOCK; b++) begin
                field_q[b] <= '0;
            end
        end else begin
            // flush lasts one cycle
            ctrl_q.flush <= 1'b0;
            base_load_q  <= 1'b0;
            if (accept_pulse_i) begin
                accept_cnt_q <= accept_cnt_q + 8'd1;
            end
            if (wr) begin
                case (paddr_i)
                    REG_CTRL:        ctrl_q        <= ctrl_reg_t'(pwdata_i[1:0]);
                    REG_BOUND:       bound_q       <= block_addr_t'(pwdata_i[1:0]);
                    REG_BASE_SPIN:   base_spin_q   <= spin_vec_t'(pwdata_i[15:0]);
                    REG_BASE_ENERGY: begin
                        base_energy_q <= energy_t'(pwdata_i[15:0]);
                        base_load_q   <= 1'b1;
                    end
                    default: begin
                        if (field_sel) begin
                            field_q[field_idx] <= field_word_t'(pwdata_i[15:0]);
                        end
                    end
                endcase
            end
        end
    end

    assign enable_o      = ctrl_q.enable;
    assign flush_o       = ctrl_q.flush;
    assign bound_o       = bound_q;
    assign field_word_o  = field_q[field_addr_i];
    assign base_load_o   = base_load_q;
    assign base_spin_o   = base_spin_q;
    assign base_energy_o = base_energy_q;

endmodule

`default_nettype wire

/* flip_filter.sv */
/*
 * Flip filter: compares a proposal with the baseline spins
 * and issues one read request per flipped block up to the
 * bound, lowest block first. Holds off new proposals until
 * the previous result has retired.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ising_consts.svh"

module flip_filter import ising_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        enable_i,
    input  wire logic        flush_i,
    input  wire block_addr_t bound_i,
    input  wire spin_vec_t   baseline_spin_i,
    input  wire logic        spin_valid_i,
    output logic             spin_ready_o,
    input  wire spin_vec_t   spin_i,
    input  wire logic        retire_i,
    block_req_if.src         req
);
    localparam int P = `PARALLELISM;

    logic                  busy_q;
    logic                  active_q;
    logic [`NUM_BLOCK-1:0] pend_q;
    logic [`NUM_BLOCK-1:0] pend_rest;
    logic [`NUM_BLOCK-1:0] hit;
    spin_vec_t             diff;
    spin_vec_t             diff_q;
    spin_vec_t             spin_q;
    block_addr_t           pick;
    logic                  spin_take;
    logic                  req_take;

    assign spin_ready_o = enable_i & ~busy_q;
    assign spin_take    = spin_valid_i & spin_ready_o;
    assign req_take     = req.valid & req.ready;
    assign diff         = spin_i ^ baseline_spin_i;

    // flipped blocks at or below the bound
    always_comb begin
        for (int b = 0; b < `NUM_BLOCK; b++) begin
            hit[b] = (|diff[b*P +: P]) && (b <= int'(bound_i));
        end
    end

    // lowest pending block wins
    always_comb begin
        pick = '0;
        for (int b = `NUM_BLOCK - 1; b >= 0; b--) begin
            if (pend_q[b]) begin
                pick = block_addr_t'(b);
            end
        end
        pend_rest       = pend_q;
        pend_rest[pick] = 1'b0;
    end

    // an empty pending set still gives one zero-mask request for block 0
    assign req.valid = active_q;
    assign req.addr  = pick;
    assign req.mask  = pend_q[pick] ? diff_q[pick*P +: P] : '0;
    assign req.spin  = spin_q[pick*P +: P];
    assign req.last  = (pend_rest == '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q   <= 1'b0;
            active_q <= 1'b0;
            pend_q   <= '0;
        end else if (flush_i) begin
            busy_q   <= 1'b0;
            active_q <= 1'b0;
            pend_q   <= '0;
        end else begin
            if (spin_take) begin
                busy_q   <= 1'b1;
                active_q <= 1'b1;
                pend_q   <= hit;
            end else if (req_take) begin
                pend_q <= pend_rest;
                if (req.last) begin
                    active_q <= 1'b0;
                end
            end
            if (retire_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_take) begin
            diff_q <= diff;
            spin_q <= spin_i;
        end
    end

endmodule

`default_nettype wire

/* delta_energy.sv */
/*
 * Execute stage: reads the field weights of each requested
 * block and accumulates the energy change of its flipped
 * spins, then hands one delta per proposal downstream.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ising_consts.svh"

module delta_energy import ising_pkg::*; (
    input  wire logic        clk_i,
    input  wire logic        arst_n_i,
    input  wire logic        flush_i,
    block_req_if.dst         req,
    output block_addr_t      field_addr_o,
    input  wire field_word_t field_word_i,
    delta_if.src             dout
);
    localparam int P = `PARALLELISM;

    logic        beat_q;
    logic        last_q;
    block_addr_t addr_q;
    field_word_t w_q;
    block_mask_t m_q;
    block_mask_t s_q;
    energy_t     contrib;
    energy_t     acc_q;
    spin_vec_t   flips_q;
    logic        out_q;
    logic        req_take;
    logic        out_take;

    assign field_addr_o = req.addr;
    assign req.ready    = ~out_q;
    assign req_take     = req.valid & req.ready;
    assign out_take     = dout.valid & dout.ready;

    // +2h for a spin now at +1, -2h for one now at -1
    always_comb begin
        contrib = '0;
        for (int i = 0; i < P; i++) begin
            if (m_q[i]) begin
                if (s_q[i]) begin
                    contrib = contrib + (energy_t'(w_q[i]) <<< 1);
                end else begin
                    contrib = contrib - (energy_t'(w_q[i]) <<< 1);
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            beat_q  <= 1'b0;
            out_q   <= 1'b0;
            acc_q   <= '0;
            flips_q <= '0;
        end else if (flush_i) begin
            beat_q  <= 1'b0;
            out_q   <= 1'b0;
            acc_q   <= '0;
            flips_q <= '0;
        end else begin
            beat_q <= req_take;
            if (out_take) begin
                out_q   <= 1'b0;
                acc_q   <= '0;
                flips_q <= '0;
            end
            if (beat_q) begin
                acc_q                    <= acc_q + contrib;
                flips_q[addr_q*P +: P]   <= m_q;
                out_q                    <= last_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_take) begin
            last_q <= req.last;
            addr_q <= req.addr;
            w_q    <= field_word_i;
            m_q    <= req.mask;
            s_q    <= req.spin;
        end
    end

    assign dout.valid = out_q;
    assign dout.delta = acc_q;
    assign dout.flips = flips_q;

endmodule

`default_nettype wire

/* baseline_update.sv */
/*
 * Result stage: new energy, greedy accept decision,
 * result hand-off and the baseline spin/energy registers.
 */
`timescale 1ns/1ps
`default_nettype none

module baseline_update import ising_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      arst_n_i,
    input  wire logic      base_load_i,
    input  wire spin_vec_t base_spin_i,
    input  wire energy_t   base_energy_i,
    delta_if.dst           din,
    output logic           result_valid_o,
    input  wire logic      result_ready_i,
    output logic           result_accept_o,
    output energy_t        result_energy_o,
    output spin_vec_t      baseline_spin_o,
    output energy_t        baseline_energy_o,
    output logic           retire_o,
    output logic           accept_pulse_o,
    output logic           busy_o
);
    logic      res_q;
    logic      accept_q;
    energy_t   energy_q;
    spin_vec_t spin_q;
    spin_vec_t base_spin_q;
    energy_t   base_energy_q;
    energy_t   new_energy;
    logic      take;

    assign din.ready  = ~res_q;
    assign take       = din.valid & din.ready;
    assign new_energy = base_energy_q + din.delta;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_q         <= 1'b0;
            base_spin_q   <= '0;
            base_energy_q <= '0;
        end else begin
            if (take) begin
                res_q <= 1'b1;
            end
            if (retire_o) begin
                res_q <= 1'b0;
                if (accept_q) begin
                    base_spin_q   <= spin_q;
                    base_energy_q <= energy_q;
                end
            end
            // a software load overrides the result update
            if (base_load_i) begin
                base_spin_q   <= base_spin_i;
                base_energy_q <= base_energy_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            energy_q <= new_energy;
            accept_q <= (new_energy <= base_energy_q);
            spin_q   <= base_spin_q ^ din.flips;
        end
    end

    assign result_valid_o    = res_q;
    assign result_accept_o   = accept_q;
    assign result_energy_o   = energy_q;
    assign baseline_spin_o   = base_spin_q;
    assign baseline_energy_o = base_energy_q;
    assign retire_o          = res_q & result_ready_i;
    assign accept_pulse_o    = retire_o & accept_q;
    assign busy_o            = res_q;

endmodule

`default_nettype wire

/* ising_update_top.sv */
/*
 * Top of the spin-update stage: APB slave, flip filter,
 * energy execute stage and baseline result stage.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ising_consts.svh"

module ising_update_top import ising_pkg::*; (
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire logic                      psel_i,
    input  wire logic                      penable_i,
    input  wire logic                      pwrite_i,
    input  wire logic [`APB_ADDR_BITS-1:0] paddr_i,
    input  wire logic [31:0]               pwdata_i,
    output logic      [31:0]               prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  wire logic                      spin_valid_i,
    output logic                           spin_ready_o,
    input  wire spin_vec_t                 spin_i,
    output logic                           result_valid_o,
    input  wire logic                      result_ready_i,
    output logic                           result_accept_o,
    output energy_t                        result_energy_o,
    output spin_vec_t                      baseline_spin_o,
    output energy_t                        baseline_energy_o
);
    logic        enable;
    logic        flush;
    block_addr_t bound;
    block_addr_t field_addr;
    field_word_t field_word;
    logic        base_load;
    spin_vec_t   base_spin;
    energy_t     base_energy;
    logic        busy;
    logic        accept_pulse;
    logic        retire;

    block_req_if u_req_if ();
    delta_if     u_delta_if ();

    apb_ctrl u_apb_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .psel_i         (psel_i),
        .penable_i      (penable_i),
        .pwrite_i       (pwrite_i),
        .paddr_i        (paddr_i),
        .pwdata_i       (pwdata_i),
        .prdata_o       (prdata_o),
        .pready_o       (pready_o),
        .pslverr_o      (pslverr_o),
        .busy_i         (busy),
        .accept_pulse_i (accept_pulse),
        .enable_o       (enable),
        .flush_o        (flush),
        .bound_o        (bound),
        .field_addr_i   (field_addr),
        .field_word_o   (field_word),
        .base_load_o    (base_load),
        .base_spin_o    (base_spin),
        .base_energy_o  (base_energy)
    );

    flip_filter u_flip_filter (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .enable_i        (enable),
        .flush_i         (flush),
        .bound_i         (bound),
        .baseline_spin_i (baseline_spin_o),
        .spin_valid_i    (spin_valid_i),
        .spin_ready_o    (spin_ready_o),
        .spin_i          (spin_i),
        .retire_i        (retire),
        .req             (u_req_if.src)
    );

    delta_energy u_delta_energy (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush),
        .req          (u_req_if.dst),
        .field_addr_o (field_addr),
        .field_word_i (field_word),
        .dout         (u_delta_if.src)
    );

    baseline_update u_baseline_update (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .base_load_i       (base_load),
        .base_spin_i       (base_spin),
        .base_energy_i     (base_energy),
        .din               (u_delta_if.dst),
        .result_valid_o    (result_valid_o),
        .result_ready_i    (result_ready_i),
        .result_accept_o   (result_accept_o),
        .result_energy_o   (result_energy_o),
        .baseline_spin_o   (baseline_spin_o),
        .baseline_energy_o (baseline_energy_o),
        .retire_o          (retire),
        .accept_pulse_o    (accept_pulse),
        .busy_o            (busy)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
/*
 * Testbench clock and reset source:
 * 10 ns clock, reset held low for 16 cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic arst_n_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_ising_update.sv */
/*
 * Testbench of the spin-update stage: reads proposal cases,
 * programs weights, bound and baseline over APB, drives spins
 * and result back-pressure, checks results, baselines, flush
 * and the accepted count in the status register.
 */
`timescale 1ns/1ps
`default_nettype none

`include "ising_consts.svh"

module tb_ising_update import apb_regs_pkg::*; ();

    typedef struct packed {
        logic [1:0]       mode;
        logic             load;
        logic [1:0]       bound;
        logic [3:0][15:0] field;
        logic [15:0]      base_spin;
        logic [15:0]      base_energy;
        logic [15:0]      prop;
        logic [15:0]      exp_energy;
        logic             exp_accept;
    } case_t;

    logic                      clk;
    logic                      arst_n;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`APB_ADDR_BITS-1:0] paddr;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;
    logic                      spin_valid;
    logic                      spin_ready;
    logic [15:0]               spin;
    logic                      result_valid;
    logic                      result_ready;
    logic                      result_accept;
    logic [15:0]               result_energy;
    logic [15:0]               baseline_spin;
    logic [15:0]               baseline_energy;

    case_t       cases [$];
    bit          cases_ready;
    int          errors;
    int          accepts;
    logic [15:0] model_spin;
    logic [15:0] model_energy;

    tb_clk_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    ising_update_top dut (
        .clk_i             (clk),
        .arst_n_i          (arst_n),
        .psel_i            (psel),
        .penable_i         (penable),
        .pwrite_i          (pwrite),
        .paddr_i           (paddr),
        .pwdata_i          (pwdata),
        .prdata_o          (prdata),
        .pready_o          (pready),
        .pslverr_o         (pslverr),
        .spin_valid_i      (spin_valid),
        .spin_ready_o      (spin_ready),
        .spin_i            (spin),
        .result_valid_o    (result_valid),
        .result_ready_i    (result_ready),
        .result_accept_o   (result_accept),
        .result_energy_o   (result_energy),
        .baseline_spin_o   (baseline_spin),
        .baseline_energy_o (baseline_energy)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
            abort_run("stopping at the first mismatch");
        end
    endtask

    // one zero-wait APB transfer, sampled mid access phase
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        compare_value("pready_o", 32'(pready), 32'd1);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b1, addr, wdata, rdata, err);
        compare_value("pslverr_o", 32'(err), 32'd0);
    endtask

    task automatic apb_read_check(input string name, input logic [7:0] addr,
                                  input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, 32'd0, rdata, err);
        compare_value("pslverr_o", 32'(err), 32'd0);
        compare_value(name, rdata, expected);
    endtask

    // spins of the blocks at or below the bound
    function automatic logic [15:0] scan_mask(input logic [1:0] bound);
        logic [15:0] m;
        m = '0;
        for (int b = 0; b < `NUM_BLOCK; b++) begin
            if (b <= int'(bound)) begin
                m[b*`PARALLELISM +: `PARALLELISM] = '1;
            end
        end
        return m;
    endfunction

    task automatic check_baseline();
        compare_value("baseline_spin_o", 32'(baseline_spin), 32'(model_spin));
        compare_value("baseline_energy_o", 32'(baseline_energy), 32'(model_energy));
    endtask

    task automatic read_cases();
        int               fd;
        int               n;
        int               mode;
        int               load;
        int               bound;
        int               accept;
        logic [15:0]      f0;
        logic [15:0]      f1;
        logic [15:0]      f2;
        logic [15:0]      f3;
        logic [15:0]      bs;
        logic [15:0]      be;
        logic [15:0]      pr;
        logic [15:0]      ee;
        logic [8*160-1:0] line_buf;
        case_t            c;
        fd = $fopen("ising_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open ising_cases.txt");
        end
        // comment lines fail the scan and are skipped
        while ($fgets(line_buf, fd) > 0) begin
            n = $sscanf(line_buf, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        mode, load, bound, f0, f1, f2, f3, bs, be, pr, ee, accept);
            if (n == 12) begin
                c.mode        = 2'(mode);
                c.load        = 1'(load);
                c.bound       = 2'(bound);
                c.field       = {f3, f2, f1, f0};
                c.base_spin   = bs;
                c.base_energy = be;
                c.prop        = pr;
                c.exp_energy  = ee;
                c.exp_accept  = 1'(accept);
                cases.push_back(c);
            end
        end
        $fclose(fd);
        if (cases.size() == 0) begin
            abort_run("no cases found in ising_cases.txt");
        end
        cases_ready = 1'b1;
    endtask

    task automatic program_case(input case_t c);
        int b;
        apb_write(REG_BOUND, 32'(c.bound));
        apb_read_check("bound readback", REG_BOUND, 32'(c.bound));
        for (b = 0; b < `NUM_BLOCK; b++) begin
            apb_write(REG_FIELD + 8'(4 * b), 32'(c.field[b]));
            apb_read_check($sformatf("field[%0d] readback", b), REG_FIELD + 8'(4 * b),
                           32'(c.field[b]));
        end
        if (c.load) begin
            apb_write(REG_BASE_SPIN, 32'(c.base_spin));
            apb_write(REG_BASE_ENERGY, 32'(c.base_energy));
            apb_read_check("base spin readback", REG_BASE_SPIN, 32'(c.base_spin));
            apb_read_check("base energy readback", REG_BASE_ENERGY, 32'(c.base_energy));
            model_spin   = c.base_spin;
            model_energy = c.base_energy;
        end
        check_baseline();
    endtask

    task automatic send_proposal(input logic [15:0] prop);
        while (spin_ready !== 1'b1) begin
            @(negedge clk);
        end
        spin_valid = 1'b1;
        spin       = prop;
        @(negedge clk);
        spin_valid = 1'b0;
        compare_value("spin_ready_o", 32'(spin_ready), 32'd0);
    endtask

    task automatic collect_result(input case_t c);
        int stall;
        while (result_valid !== 1'b1) begin
            @(negedge clk);
        end
        compare_value("result_energy_o", 32'(result_energy), 32'(c.exp_energy));
        compare_value("result_accept_o", 32'(result_accept), 32'(c.exp_accept));
        stall = (c.mode == 2'd1) ? int'($urandom % 8) : 0;
        repeat (stall) begin
            @(negedge clk);
            compare_value("result_valid_o", 32'(result_valid), 32'd1);
            compare_value("result_energy_o", 32'(result_energy), 32'(c.exp_energy));
            compare_value("result_accept_o", 32'(result_accept), 32'(c.exp_accept));
            compare_value("spin_ready_o", 32'(spin_ready), 32'd0);
        end
        // result still pending, so status shows busy
        apb_read_check("status busy", REG_STATUS, {16'b0, 8'(accepts), 8'h01});
        check_baseline();
        result_ready = 1'b1;
        @(negedge clk);
        result_ready = 1'b0;
        compare_value("result_valid_o", 32'(result_valid), 32'd0);
        if (c.exp_accept) begin
            model_spin   = model_spin ^ ((c.prop ^ model_spin) & scan_mask(c.bound));
            model_energy = c.exp_energy;
            accepts++;
        end
        check_baseline();
    endtask

    // flush lands two edges after the spin is taken
    task automatic run_flush(input case_t c);
        while (spin_ready !== 1'b1) begin
            @(negedge clk);
        end
        fork
            apb_write(REG_CTRL, 32'h3);
            begin
                @(negedge clk);
                spin_valid = 1'b1;
                spin       = c.prop;
                @(negedge clk);
                spin_valid = 1'b0;
            end
        join
        repeat (20) begin
            @(negedge clk);
            compare_value("result_valid_o", 32'(result_valid), 32'd0);
        end
        compare_value("spin_ready_o", 32'(spin_ready), 32'd1);
        check_baseline();
    endtask

    initial begin : main_seq
        logic [31:0] rdata;
        logic        err;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        spin_valid   = 1'b0;
        spin         = '0;
        result_ready = 1'b0;
        errors       = 0;
        accepts      = 0;
        cases_ready  = 1'b0;
        model_spin   = '0;
        model_energy = '0;
        void'($urandom(12188));
        read_cases();
        wait (arst_n === 1'b1);
        @(negedge clk);
        compare_value("spin_ready_o", 32'(spin_ready), 32'd0);
        compare_value("result_valid_o", 32'(result_valid), 32'd0);
        compare_value("pready_o", 32'(pready), 32'd0);
        compare_value("pslverr_o", 32'(pslverr), 32'd0);
        check_baseline();
        apb_read_check("ctrl readback", REG_CTRL, 32'd0);
        apb_write(REG_CTRL, 32'd1);
        apb_read_check("ctrl readback", REG_CTRL, 32'd1);
        // unmapped offsets
        apb_access(1'b0, 8'h14, 32'd0, rdata, err);
        compare_value("pslverr_o", 32'(err), 32'd1);
        apb_access(1'b1, 8'h20, 32'hFFFF, rdata, err);
        compare_value("pslverr_o", 32'(err), 32'd1);
        foreach (cases[i]) begin
            program_case(cases[i]);
            if (cases[i].mode == 2'd2) begin
                run_flush(cases[i]);
            end else begin
                send_proposal(cases[i].prop);
                collect_result(cases[i]);
            end
        end
        apb_read_check("status readback", REG_STATUS, {16'b0, 8'(accepts), 8'b0});
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (cases_ready);
        limit = 200 * cases.size() + 400;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("watchdog expired, run did not finish within %0d cycles", limit));
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
ising_pkg.sv
apb_regs_pkg.sv
ising_ifs.sv
apb_ctrl.sv
flip_filter.sv
delta_energy.sv
baseline_update.sv
ising_update_top.sv
tb_clk_gen.sv
tb_ising_update.sv

/* ising_cases.txt */
# mode load bound field0 field1 field2 field3 base_spin base_energy proposal energy accept
# all hex; mode 0 plain, 1 random result stalls, 2 flush mid-scan; load 1 writes the baseline
# single and multi block flips, unchanged proposal
0 1 3 F321 5D4E 2087 B16C 0000 0010 0001 0012 0
0 0 3 F321 5D4E 2087 B16C 0000 0000 0008 000E 1
0 0 3 F321 5D4E 2087 B16C 0000 0000 0030 0014 0
0 0 3 F321 5D4E 2087 B16C 0000 0000 0008 000E 1
0 0 3 F321 5D4E 2087 B16C 0000 0000 8408 0004 1
# bound below 3 hides the upper blocks
0 0 1 F321 5D4E 2087 B16C 0000 0000 0448 FFFE 1
0 0 0 F321 5D4E 2087 B16C 0000 0000 0000 0000 0
0 0 2 F321 5D4E 2087 B16C 0000 0000 0443 0006 0
# result back-pressure
1 1 3 F321 5D4E 2087 B16C FFFF 0100 FFFE 00FE 1
1 0 3 F321 5D4E 2087 B16C 0000 0000 0FFE 0102 0
1 0 3 F321 5D4E 2087 B16C 0000 0000 F0FE 00FC 1
1 0 3 F321 5D4E 2087 B16C 0000 0000 F0F0 00F4 1
1 0 3 F321 5D4E 2087 B16C 0000 0000 0F0F 00FC 0
# flush during a four block scan, then the same baseline again
2 0 3 F321 5D4E 2087 B16C 0000 0000 0F0F 0000 0
0 0 3 F321 5D4E 2087 B16C 0000 0000 F0F1 00F6 0
0 0 3 F321 5D4E 2087 B16C 0000 0000 F0F0 00F4 1
# negative energies
1 1 3 F321 5D4E 2087 B16C 1234 FFF0 1235 FFF2 0
1 0 3 F321 5D4E 2087 B16C 0000 0000 1230 FFEA 1
# extreme weights, every spin flipped
0 1 3 7777 7777 7777 7777 0000 0000 FFFF 00E0 0
0 0 3 8888 8888 8888 8888 0000 0000 FFFF FF00 1
